/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_arm_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/alu.sv */
// data-processing ALU working on the ARM opcode, gives the result and the new NZCV
module alu (
    input  logic [3:0]                 i_opcode,
    input  logic [arm_pkg::XLEN-1:0]   i_x,
    input  logic [arm_pkg::XLEN-1:0]   i_y,
    input  logic [arm_pkg::NZCV_W-1:0] i_flags,
    output logic [arm_pkg::XLEN-1:0]   o_result,
    output logic [arm_pkg::NZCV_W-1:0] o_nzcv
);
    import arm_pkg::*;

    logic            is_arith;
    logic            is_sub;
    logic            cin;
    logic [XLEN-1:0] y_op;
    logic [XLEN:0]   sum;
    logic            c;
    logic            v;

    // subtract is x + ~y + 1, so C comes out as not borrow
    assign is_sub = (i_opcode == OP_SUB) | (i_opcode == OP_CMP) | (i_opcode == OP_SBC);
    assign y_op   = is_sub ? ~i_y : i_y;
    assign sum    = {1'b0, i_x} + {1'b0, y_op} + {{XLEN{1'b0}}, cin};

    always_comb begin
        is_arith = 1'b0;
        cin      = 1'b0;
        case (i_opcode)
            OP_AND, OP_TST: o_result = i_x & i_y;
            OP_EOR:         o_result = i_x ^ i_y;
            OP_ORR:         o_result = i_x | i_y;
            OP_MOV:         o_result = i_y;
            OP_MVN:         o_result = ~i_y;
            OP_ADD: begin
                is_arith = 1'b1;
                o_result = sum[XLEN-1:0];
            end
            OP_SUB, OP_CMP: begin
                is_arith = 1'b1;
                cin      = 1'b1;
                o_result = sum[XLEN-1:0];
            end
            OP_ADC, OP_SBC: begin
                is_arith = 1'b1;
                cin      = i_flags[1]; // sbc takes not c via ~y
                o_result = sum[XLEN-1:0];
            end
            default:        o_result = '0;
        endcase
    end

    assign c = is_arith ? sum[XLEN] : i_flags[1];
    assign v = is_arith ? (i_x[XLEN-1] == y_op[XLEN-1]) & (sum[XLEN-1] != i_x[XLEN-1])
                        : i_flags[0];

    assign o_nzcv = {o_result[XLEN-1], o_result == '0, c, v};

endmodule

/* rtl/arm_core_top.sv */
// top level of the ARM32 execute core, fed by a Wishbone slave and reporting on a retire port
module arm_core_top (
    input  logic                         clk,
    input  logic                         i_reset_n,
    input  logic                         i_wb_cyc,
    input  logic                         i_wb_stb,
    input  logic                         i_wb_we,
    input  logic [arm_pkg::XLEN-1:0]     i_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_retire_valid,
    output logic                         o_retire_wb_en,
    output logic [arm_pkg::REG_ADDR_W-1:0] o_retire_rd,
    output logic [arm_pkg::XLEN-1:0]     o_retire_data,
    output logic [arm_pkg::NZCV_W-1:0]   o_retire_nzcv
);
    import arm_pkg::*;

    logic                  instr_valid;
    logic [XLEN-1:0]       instr;
    logic                  dec_valid;
    logic [3:0]            dec_cond;
    logic [1:0]            dec_type;
    logic [3:0]            dec_opcode;
    logic                  dec_set_flags;
    logic                  dec_is_imm;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0]       dec_rn_val;
    logic [XLEN-1:0]       dec_rm_val;
    operand2_u             dec_operand2;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    wb_instr_port u_port (
        .clk(clk), .i_reset_n(i_reset_n),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we), .i_wb_dat(i_wb_dat),
        .o_wb_ack(o_wb_ack), .o_instr_valid(instr_valid), .o_instr(instr)
    );

    decode_stage u_decode (
        .clk(clk), .i_reset_n(i_reset_n),
        .i_instr_valid(instr_valid), .i_instr(instr),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .o_valid(dec_valid), .o_cond(dec_cond), .o_type(dec_type), .o_opcode(dec_opcode),
        .o_set_flags(dec_set_flags), .o_is_imm(dec_is_imm), .o_rd(dec_rd),
        .o_rn_val(dec_rn_val), .o_rm_val(dec_rm_val), .o_operand2(dec_operand2)
    );

    execute_stage u_execute (
        .clk(clk), .i_reset_n(i_reset_n),
        .i_valid(dec_valid), .i_cond(dec_cond), .i_type(dec_type), .i_opcode(dec_opcode),
        .i_set_flags(dec_set_flags), .i_is_imm(dec_is_imm), .i_rd(dec_rd),
        .i_rn_val(dec_rn_val), .i_rm_val(dec_rm_val), .i_operand2(dec_operand2),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
        .o_retire_valid(o_retire_valid), .o_retire_wb_en(o_retire_wb_en),
        .o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data),
        .o_retire_nzcv(o_retire_nzcv)
    );

endmodule

/* rtl/arm_pkg.sv */
// shared widths, ARM encodings and the operand-2 field layout, imported by the core RTL
package arm_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS   = 16;
    localparam int NZCV_W     = 4;

    // data-processing opcodes, bits 24:21
    localparam logic [3:0] OP_AND = 4'b0000;
    localparam logic [3:0] OP_EOR = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_ADD = 4'b0100;
    localparam logic [3:0] OP_ADC = 4'b0101;
    localparam logic [3:0] OP_SBC = 4'b0110;
    localparam logic [3:0] OP_TST = 4'b1000;
    localparam logic [3:0] OP_CMP = 4'b1010;
    localparam logic [3:0] OP_ORR = 4'b1100;
    localparam logic [3:0] OP_MOV = 4'b1101;
    localparam logic [3:0] OP_MVN = 4'b1111;

    localparam logic [3:0] COND_EQ = 4'b0000;
    localparam logic [3:0] COND_NE = 4'b0001;
    localparam logic [3:0] COND_CS = 4'b0010;
    localparam logic [3:0] COND_CC = 4'b0011;
    localparam logic [3:0] COND_MI = 4'b0100;
    localparam logic [3:0] COND_PL = 4'b0101;
    localparam logic [3:0] COND_VS = 4'b0110;
    localparam logic [3:0] COND_VC = 4'b0111;
    localparam logic [3:0] COND_HI = 4'b1000;
    localparam logic [3:0] COND_LS = 4'b1001;
    localparam logic [3:0] COND_GE = 4'b1010;
    localparam logic [3:0] COND_LT = 4'b1011;
    localparam logic [3:0] COND_GT = 4'b1100;
    localparam logic [3:0] COND_LE = 4'b1101;
    localparam logic [3:0] COND_AL = 4'b1110;

    localparam logic [1:0] SH_LSL = 2'b00;
    localparam logic [1:0] SH_LSR = 2'b01;
    localparam logic [1:0] SH_ASR = 2'b10;
    localparam logic [1:0] SH_ROR = 2'b11;

    localparam logic [1:0] TYPE_DP = 2'b00;

    // low twelve bits of a data-processing word, meaning depends on the I bit
    typedef union packed {
        struct packed {
            logic [3:0] rotate;
            logic [7:0] imm8;
        } imm_view;
        struct packed {
            logic [4:0] shift_amt;
            logic [1:0] shift_kind;
            logic       zero;       // 0 for shift by immediate
            logic [3:0] rm;
        } reg_view;
    } operand2_u;

endpackage

/* rtl/decode_stage.sv */
// decode stage, splits the instruction into fields and registers operands read from the bank
module decode_stage (
    input  logic                           clk,
    input  logic                           i_reset_n,
    input  logic                           i_instr_valid,
    input  logic [arm_pkg::XLEN-1:0]       i_instr,
    input  logic                           i_wr_en,
    input  logic [arm_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [arm_pkg::XLEN-1:0]       i_wr_data,
    output logic                           o_valid,
    output logic [3:0]                     o_cond,
    output logic [1:0]                     o_type,
    output logic [3:0]                     o_opcode,
    output logic                           o_set_flags,
    output logic                           o_is_imm,
    output logic [arm_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [arm_pkg::XLEN-1:0]       o_rn_val,
    output logic [arm_pkg::XLEN-1:0]       o_rm_val,
    output arm_pkg::operand2_u             o_operand2
);
    import arm_pkg::*;

    operand2_u       op2;
    logic [3:0]      opcode;
    logic [XLEN-1:0] rn_val;
    logic [XLEN-1:0] rm_val;

    assign op2    = i_instr[11:0];
    assign opcode = i_instr[24:21];

    register_bank u_regs (
        .clk(clk), .i_reset_n(i_reset_n),
        .i_rd_addr_a(i_instr[19:16]), .i_rd_addr_b(op2.reg_view.rm),
        .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
        .o_rd_data_a(rn_val), .o_rd_data_b(rm_val)
    );

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_instr_valid) begin
            o_cond      <= i_instr[31:28];
            o_type      <= i_instr[27:26];
            o_is_imm    <= i_instr[25];
            o_opcode    <= opcode;
            o_set_flags <= i_instr[20] | (opcode == OP_TST) | (opcode == OP_CMP); // compares always set
            o_rd        <= i_instr[15:12];
            o_rn_val    <= rn_val;
            o_rm_val    <= rm_val;
            o_operand2  <= op2;
        end
    end

endmodule

/* rtl/execute_stage.sv */
// execute stage, checks the condition, runs shifter and ALU, keeps NZCV and drives write and retire
module execute_stage (
    input  logic                           clk,
    input  logic                           i_reset_n,
    input  logic                           i_valid,
    input  logic [3:0]                     i_cond,
    input  logic [1:0]                     i_type,
    input  logic [3:0]                     i_opcode,
    input  logic                           i_set_flags,
    input  logic                           i_is_imm,
    input  logic [arm_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [arm_pkg::XLEN-1:0]       i_rn_val,
    input  logic [arm_pkg::XLEN-1:0]       i_rm_val,
    input  arm_pkg::operand2_u             i_operand2,
    output logic                           o_wr_en,
    output logic [arm_pkg::REG_ADDR_W-1:0] o_wr_addr,
    output logic [arm_pkg::XLEN-1:0]       o_wr_data,
    output logic                           o_retire_valid,
    output logic                           o_retire_wb_en,
    output logic [arm_pkg::REG_ADDR_W-1:0] o_retire_rd,
    output logic [arm_pkg::XLEN-1:0]       o_retire_data,
    output logic [arm_pkg::NZCV_W-1:0]     o_retire_nzcv
);
    import arm_pkg::*;

    logic [NZCV_W-1:0] flags;
    logic              n, z, c, v;
    logic              cond_pass;
    logic              executed;
    logic              is_compare;
    logic [XLEN-1:0]   op2_val;
    logic [XLEN-1:0]   alu_result;
    logic [NZCV_W-1:0] alu_nzcv;
    logic              wb_en_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]   data_q;

    assign {n, z, c, v} = flags;

    always_comb begin
        case (i_cond)
            COND_EQ: cond_pass = z;
            COND_NE: cond_pass = ~z;
            COND_CS: cond_pass = c;
            COND_CC: cond_pass = ~c;
            COND_MI: cond_pass = n;
            COND_PL: cond_pass = ~n;
            COND_VS: cond_pass = v;
            COND_VC: cond_pass = ~v;
            COND_HI: cond_pass = c & ~z;
            COND_LS: cond_pass = ~c | z;
            COND_GE: cond_pass = (n == v);
            COND_LT: cond_pass = (n != v);
            COND_GT: cond_pass = ~z & (n == v);
            COND_LE: cond_pass = z | (n != v);
            COND_AL: cond_pass = 1'b1;
            default: cond_pass = 1'b1; // 1111 runs as always
        endcase
    end

    assign executed   = i_valid & cond_pass & (i_type == TYPE_DP);
    assign is_compare = (i_opcode == OP_TST) | (i_opcode == OP_CMP);

    operand_shifter u_shift (
        .i_is_imm(i_is_imm), .i_operand2(i_operand2), .i_rm_val(i_rm_val),
        .o_operand2_val(op2_val)
    );

    alu u_alu (
        .i_opcode(i_opcode), .i_x(i_rn_val), .i_y(op2_val), .i_flags(flags),
        .o_result(alu_result), .o_nzcv(alu_nzcv)
    );

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            flags          <= '0;
            wb_en_q        <= 1'b0;
            o_retire_valid <= 1'b0;
        end else begin
            if (executed && i_set_flags) begin
                flags <= alu_nzcv;
            end
            wb_en_q        <= executed & ~is_compare;
            o_retire_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            rd_q   <= i_rd;
            data_q <= alu_result; // reported even when not written
        end
    end

    assign o_wr_en        = wb_en_q;
    assign o_wr_addr      = rd_q;
    assign o_wr_data      = data_q;
    assign o_retire_wb_en = wb_en_q;
    assign o_retire_rd    = rd_q;
    assign o_retire_data  = data_q;
    assign o_retire_nzcv  = flags; // already holds this word's update

endmodule

/* rtl/operand_shifter.sv */
// forms operand 2 from a rotated 8-bit immediate or a shifted Rm value
module operand_shifter (
    input  logic                     i_is_imm,
    input  arm_pkg::operand2_u       i_operand2,
    input  logic [arm_pkg::XLEN-1:0] i_rm_val,
    output logic [arm_pkg::XLEN-1:0] o_operand2_val
);
    import arm_pkg::*;

    logic [XLEN-1:0]   imm32;
    logic [4:0]        rot_amt;
    logic [4:0]        sh_amt;
    logic [2*XLEN-1:0] imm_rot;
    logic [2*XLEN-1:0] rm_rot;
    logic [XLEN-1:0]   rm_shifted;

    assign imm32   = {{(XLEN-8){1'b0}}, i_operand2.imm_view.imm8};
    assign rot_amt = {i_operand2.imm_view.rotate, 1'b0}; // twice the rotate field
    assign sh_amt  = i_operand2.reg_view.shift_amt;

    // rotate as a right shift of the doubled word
    assign imm_rot = {imm32, imm32} >> rot_amt;
    assign rm_rot  = {i_rm_val, i_rm_val} >> sh_amt;

    always_comb begin
        case (i_operand2.reg_view.shift_kind)
            SH_LSL:  rm_shifted = i_rm_val << sh_amt;
            SH_LSR:  rm_shifted = i_rm_val >> sh_amt;
            SH_ASR:  rm_shifted = $signed(i_rm_val) >>> sh_amt;
            SH_ROR:  rm_shifted = rm_rot[XLEN-1:0];
            default: rm_shifted = i_rm_val;
        endcase
    end

    assign o_operand2_val = i_is_imm ? imm_rot[XLEN-1:0] : rm_shifted;

endmodule

/* rtl/register_bank.sv */
// sixteen general registers, two combinational read ports and one clocked write port
module register_bank (
    input  logic                           clk,
    input  logic                           i_reset_n,
    input  logic [arm_pkg::REG_ADDR_W-1:0] i_rd_addr_a,
    input  logic [arm_pkg::REG_ADDR_W-1:0] i_rd_addr_b,
    input  logic                           i_wr_en,
    input  logic [arm_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [arm_pkg::XLEN-1:0]       i_wr_data,
    output logic [arm_pkg::XLEN-1:0]       o_rd_data_a,
    output logic [arm_pkg::XLEN-1:0]       o_rd_data_b
);
    import arm_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // a write landing on the same edge as the decode capture is seen by the read
    assign o_rd_data_a = (i_wr_en && i_wr_addr == i_rd_addr_a) ? i_wr_data : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_wr_en && i_wr_addr == i_rd_addr_b) ? i_wr_data : regs[i_rd_addr_b];

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

/* rtl/wb_instr_port.sv */
// Wishbone classic slave that acks each request once and passes written words to decode
module wb_instr_port (
    input  logic                     clk,
    input  logic                     i_reset_n,
    input  logic                     i_wb_cyc,
    input  logic                     i_wb_stb,
    input  logic                     i_wb_we,
    input  logic [arm_pkg::XLEN-1:0] i_wb_dat,
    output logic                     o_wb_ack,
    output logic                     o_instr_valid,
    output logic [arm_pkg::XLEN-1:0] o_instr
);
    logic req;
    logic accept;

    assign req    = i_wb_cyc & i_wb_stb & ~o_wb_ack; // no ack two cycles running
    assign accept = req & i_wb_we;                   // reads get acked, never issued

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            o_wb_ack      <= 1'b0;
            o_instr_valid <= 1'b0;
        end else begin
            o_wb_ack      <= req;
            o_instr_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_instr <= i_wb_dat;
        end
    end

endmodule

/* verification/arm_core_tests.mem */
// first value is the number of tests, then one test per line, all hex
// instruction word, expected wb_en, expected rd, expected data, expected nzcv
19
E3A01005 1 1 00000005 0 // mov r1, #5
E3A024FF 1 2 FF000000 0 // mov r2, #ff ror 8
E3A03F3F 1 3 000000FC 0 // mov r3, #3f ror 30
E0814002 1 4 FF000005 0 // add r4, r1, r2
E0435001 1 5 000000F7 0 // sub r5, r3, r1
E203600F 1 6 0000000C 0 // and r6, r3, #f
E1827001 1 7 FF000005 0 // orr r7, r2, r1
E0248003 1 8 FF0000F9 0 // eor r8, r4, r3
E1A09201 1 9 00000050 0 // mov r9, r1 lsl 4
E1A0A422 1 A 00FF0000 0 // mov r10, r2 lsr 8
E1A0B242 1 B FFF00000 0 // mov r11, r2 asr 4
E1A0C263 1 C C000000F 0 // mov r12, r3 ror 4
E3510005 0 0 00000000 6 // cmp r1, #5
03A0D007 1 D 00000007 6 // moveq r13, #7
13A0D009 0 D 00000009 6 // movne r13, #9
E1A0000D 1 0 00000007 6 // mov r0, r13
E0A1E001 1 E 0000000B 6 // adc r14, r1, r1 with carry set
E31204FF 0 0 FF000000 A // tst r2, #ff ror 8
E0519003 1 9 FFFFFF09 8 // subs r9, r1, r3
E0C1A001 1 A FFFFFFFF 8 // sbc r10, r1, r1 with carry clear
A3A05001 0 5 00000001 8 // movge r5, #1
B3A06002 1 6 00000002 8 // movlt r6, #2
E1A04005 1 4 000000F7 8 // mov r4, r5
E4514001 0 4 00000000 8 // type 01 word, no write, flags kept
E3E03000 1 3 FFFFFFFF 8 // mvn r3, #0

/* verification/tb_arm_core.sv */
// top-level testbench that sends words from the tests file to the core over Wishbone and checks each retire
module tb_arm_core;
    import arm_pkg::*;

    localparam int MAX_TESTS    = 64;
    localparam int COLS         = 5;  // instr, wb_en, rd, data, nzcv
    localparam int RESET_CYCLES = 16;

    logic                  clk;
    logic                  reset_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [XLEN-1:0]       wb_dat;
    logic                  wb_ack;
    logic                  retire_valid;
    logic                  retire_wb_en;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;
    logic [NZCV_W-1:0]     retire_nzcv;

    logic [31:0] test_mem [0:COLS*MAX_TESTS]; // word 0 holds the test count
    int          num_tests;
    int          cycle_limit;
    int          cycles;
    int          retired;
    int          pending [$];                 // indices of acked words
    logic [31:0] rand_state;

    tb_clock_gen u_clk (
        .o_clk(clk)
    );

    arm_core_top dut0 (
        .clk(clk), .i_reset_n(reset_n),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we), .i_wb_dat(wb_dat),
        .o_wb_ack(wb_ack),
        .o_retire_valid(retire_valid), .o_retire_wb_en(retire_wb_en),
        .o_retire_rd(retire_rd), .o_retire_data(retire_data),
        .o_retire_nzcv(retire_nzcv)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_retire(input int idx);
        string name;
        int    base;
        name = $sformatf("test %0d", idx);
        base = 1 + COLS*idx;
        check_value({name, " wb_en"}, test_mem[base+1], {31'b0, retire_wb_en});
        check_value({name, " rd"}, test_mem[base+2], {28'b0, retire_rd});
        check_value({name, " data"}, test_mem[base+3], retire_data);
        check_value({name, " nzcv"}, test_mem[base+4], {28'b0, retire_nzcv});
    endtask

    // one Wishbone write, held until the ack is seen
    task automatic write_word(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = test_mem[1 + COLS*idx];
        do begin
            @(negedge clk);
            waited++;
        end while (wb_ack !== 1'b1);
        // ack comes one cycle after the request
        check_value($sformatf("test %0d ack delay", idx), 32'd1, waited);
        pending.push_back(idx);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    always @(negedge clk) begin
        if (retire_valid === 1'b1) begin
            retired++;
            if (pending.size() > 0) begin
                check_retire(pending.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            stop_on_failure($sformatf("timeout after %0d cycles, %0d of %0d words retired",
                                      cycles, retired, num_tests));
        end
    end

    initial begin
        reset_n     = 1'b1; // reset is active high
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_dat      = '0;
        cycles      = 0;
        retired     = 0;
        cycle_limit = 0;
        rand_state  = 32'h2175;
        $readmemh("verification/arm_core_tests.mem", test_mem);
        num_tests = int'(test_mem[0]);
        if (num_tests < 1 || num_tests > MAX_TESTS) begin
            stop_on_failure($sformatf("tests file gives %0d tests, allowed are 1 to %0d",
                                      num_tests, MAX_TESTS));
        end
        cycle_limit = num_tests*8 + 40;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;

        for (int i = 0; i < num_tests; i++) begin
            write_word(i);
            rand_state = xorshift32(rand_state);
            repeat (rand_state[1:0]) @(negedge clk); // 0 to 3 idle cycles
        end

        while (pending.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // catch stray retires

        if (retired == num_tests) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_on_failure($sformatf("%0d retire pulses seen for %0d words",
                                      retired, num_tests));
        end
    end

endmodule

/* verification/tb_clock_gen.sv */
// free-running testbench clock, period 100, instantiated by the core testbench
module tb_clock_gen (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk; // half period
        end
    end

endmodule

/* verilog.f */
rtl/arm_pkg.sv
rtl/register_bank.sv
rtl/operand_shifter.sv
rtl/alu.sv
rtl/wb_instr_port.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/arm_core_top.sv
verification/tb_clock_gen.sv
verification/tb_arm_core.sv
